// ==== hdl/fp_pkg.sv ====
package fp_pkg;

	// single precision layout.
	localparam int fp_width = 32;
	localparam int exp_width = 8;
	localparam int man_width = 23;
	localparam int exp_bias = 127;

	localparam int exp_max = (1 << exp_width) - 1;   // all ones exponent.

	// leading zero count covers the hidden bit and the fraction.
	localparam int lz_width = $clog2(man_width + 2);

	typedef logic [fp_width-1:0] fp_word;

	localparam fp_word fp_zero = '0;

endpackage

// ==== hdl/node_pkg.sv ====
package node_pkg;
	import fp_pkg::*;

	localparam int node_inputs = 30;
	localparam int tree_levels = 5;

	// sums yielded by each adder level.
	localparam int level_width [tree_levels] = '{15, 8, 4, 2, 1};

	// operands entering each level.
	// an odd count gets a zero partner.
	localparam int level_inputs [tree_levels] = '{
		node_inputs,
		level_width[0],
		level_width[1],
		level_width[2],
		level_width[3]
	};

	localparam int activation_width = node_inputs * fp_width;

	localparam fp_word node_weights [node_inputs] = '{
		32'h3E053147, 32'h3DE5DACF, 32'h3E66DC6D, 32'hBE991BF3, 32'hBE510BB2,
		32'hBE94426D, 32'h3D8AB2F1, 32'h3EAE6C08, 32'hBEEC68E2, 32'hBE57D802,
		32'h3EA425FA, 32'hBD98B893, 32'hBD83C810, 32'hBF01F903, 32'hBEAF03D8,
		32'h3E14BEE8, 32'h3CAFC6A3, 32'hBE45825E, 32'h3DDCB627, 32'h3E13FAA8,
		32'hBE560F3F, 32'h3D9F9B3A, 32'hBE82C88C, 32'h3DD7AA41, 32'hBC619E12,
		32'h3E27E553, 32'h3E6AA462, 32'hBE2D63B6, 32'h3D8DB614, 32'hBE8198FA
	};

endpackage

// ==== hdl/fp_mult.sv ====
`timescale 1ns/1ps

module fp_mult
(
	input fp_pkg::fp_word x,
	input fp_pkg::fp_word y,
	output fp_pkg::fp_word z
);
	import fp_pkg::*;

	logic [exp_width-1:0] exp_x;
	logic [exp_width-1:0] exp_y;
	logic sign;
	logic [2*man_width+1:0] product;
	logic signed [exp_width+1:0] exp_sum;
	logic signed [exp_width+1:0] exp_z;
	logic [man_width-1:0] man_z;

	assign exp_x = x[fp_width-2 -: exp_width];
	assign exp_y = y[fp_width-2 -: exp_width];
	assign sign = x[fp_width-1] ^ y[fp_width-1];

	// hidden bits restored before the multiply.
	assign product = {1'b1, x[man_width-1:0]} * {1'b1, y[man_width-1:0]};
	assign exp_sum = {2'b00, exp_x} + {2'b00, exp_y} - (exp_width+2)'(exp_bias);

	// product lies in [1,4), so at most one place of normalisation.
	always_comb
	begin
		if (product[2*man_width+1])
		begin
			man_z = product[2*man_width -: man_width];
			exp_z = exp_sum + 1'b1;
		end
		else
		begin
			man_z = product[2*man_width-1 -: man_width];   // low bits dropped.
			exp_z = exp_sum;
		end
	end

	always_comb
	begin
		if (exp_x == '0 || exp_y == '0 || exp_z <= 0)
			z = fp_zero;   // zero, subnormal or underflow.
		else if (exp_z >= exp_max)
			z = {sign, exp_width'(exp_max), {man_width{1'b0}}};
		else
			z = {sign, exp_z[exp_width-1:0], man_z};
	end

	always_comb
	begin
		if (!$isunknown({x, y}))
			assert (exp_x != exp_width'(exp_max) && exp_y != exp_width'(exp_max))
			else $error("fp_mult operand has an all ones exponent");
	end

endmodule

// ==== hdl/fp_adder.sv ====
`timescale 1ns/1ps

module fp_adder
(
	input fp_pkg::fp_word a,
	input fp_pkg::fp_word b,
	output fp_pkg::fp_word sum
);
	import fp_pkg::*;

	fp_word big;
	fp_word little;
	logic [exp_width-1:0] exp_big;
	logic [exp_width-1:0] exp_diff;
	logic [man_width+1:0] man_big;   // carry, hidden bit, fraction.
	logic [man_width+1:0] man_small;
	logic [man_width+1:0] man_raw;
	logic [man_width:0] man_shift;
	logic [lz_width-1:0] lz;
	logic signed [exp_width+1:0] exp_norm;
	logic [man_width-1:0] man_out;

	// exponent and fraction compare as one unsigned magnitude.
	always_comb
	begin
		if (a[fp_width-2:0] >= b[fp_width-2:0])
		begin
			big = a;
			little = b;
		end
		else
		begin
			big = b;
			little = a;
		end
	end

	always_comb
	begin
		exp_big = big[fp_width-2 -: exp_width];
		exp_diff = exp_big - little[fp_width-2 -: exp_width];
		man_big = {2'b01, big[man_width-1:0]};
		man_small = {2'b01, little[man_width-1:0]} >> exp_diff;   // shifted out bits are lost.
		if (big[fp_width-1] == little[fp_width-1])
			man_raw = man_big + man_small;
		else
			man_raw = man_big - man_small;   // never negative since big is larger.
	end

	// leading zero count over hidden bit and fraction.
	always_comb
	begin
		lz = '0;
		for (int i = 0; i <= man_width; i++)
			if (man_raw[i])
				lz = lz_width'(man_width - i);
		man_shift = man_raw[man_width:0] << lz;
		if (man_raw[man_width+1])
		begin
			man_out = man_raw[man_width:1];   // carry out of the add.
			exp_norm = {2'b00, exp_big} + 1'b1;
		end
		else
		begin
			man_out = man_shift[man_width-1:0];
			exp_norm = {2'b00, exp_big} - {{(exp_width+2-lz_width){1'b0}}, lz};
		end
	end

	always_comb
	begin
		if (a[fp_width-2 -: exp_width] == '0)
			sum = b;
		else if (b[fp_width-2 -: exp_width] == '0)
			sum = a;
		else if (man_raw == '0 || exp_norm <= 0)
			sum = fp_zero;   // cancellation or underflow.
		else if (exp_norm >= exp_max)
			sum = {big[fp_width-1], exp_width'(exp_max), {man_width{1'b0}}};
		else
			sum = {big[fp_width-1], exp_norm[exp_width-1:0], man_out};
	end

endmodule

// ==== hdl/pipe_stage.sv ====
`timescale 1ns/1ps

module pipe_stage
#(
	parameter type payload_t = logic
)
(
	input logic clk,
	input logic reset,
	input logic advance,
	input logic in_valid,
	input payload_t in_data,
	output logic out_valid,
	output payload_t out_data
);

	always_ff @(posedge clk)
	begin
		if (reset)
			out_valid <= 1'b0;
		else if (advance)
			out_valid <= in_valid;   // bubbles move along too.
	end

	always_ff @(posedge clk)
	begin
		if (advance && in_valid)
			out_data <= in_data;
	end

	// the stage feeding this one must hold its item through a stall.
	input_held: assert property (@(posedge clk) disable iff (reset)
		!advance && in_valid |=> in_valid && $stable(in_data))
		else $error("pipe_stage input changed during a stall");

endmodule

// ==== hdl/handshake_in.sv ====
`timescale 1ns/1ps

module handshake_in
(
	input logic clk,
	input logic reset,
	input logic in_req,
	input logic [node_pkg::activation_width-1:0] activations,
	input logic advance,
	output logic in_ack,
	output logic cap_valid,
	output logic [node_pkg::activation_width-1:0] cap_data
);
	import node_pkg::*;

	typedef enum logic {hs_idle, hs_acked} hs_state_t;

	hs_state_t state;
	logic capture;
	logic pending;   // captured, not yet passed on.
	logic [activation_width-1:0] hold_data;

	assign capture = (state == hs_idle) && in_req && advance;
	assign in_ack = (state == hs_acked);

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= hs_idle;
		else if (capture)
			state <= hs_acked;
		else if (state == hs_acked && !in_req)
			state <= hs_idle;   // return to zero phase.
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pending <= 1'b0;
			cap_valid <= 1'b0;
		end
		else if (advance)
		begin
			pending <= capture;
			cap_valid <= pending;
		end
	end

	always_ff @(posedge clk)
	begin
		if (capture)
			hold_data <= activations;
		if (advance && pending)
			cap_data <= hold_data;
	end

	// the source keeps its request and vector until it has seen in_ack.
	req_held: assert property (@(posedge clk) disable iff (reset)
		in_req && !in_ack |=> in_ack || (in_req && $stable(activations)))
		else $error("request or vector changed before in_ack");

endmodule

// ==== hdl/relu_out.sv ====
`timescale 1ns/1ps

module relu_out
(
	input logic clk,
	input logic reset,
	input logic sum_valid,
	input fp_pkg::fp_word sum,
	input logic out_ack,
	output logic out_req,
	output fp_pkg::fp_word result,
	output logic full
);
	import fp_pkg::*;

	logic load;

	// busy until the acknowledge has returned low.
	assign full = out_req || out_ack;
	assign load = sum_valid && !full;

	always_ff @(posedge clk)
	begin
		if (reset)
			out_req <= 1'b0;
		else if (load)
			out_req <= 1'b1;
		else if (out_ack)
			out_req <= 1'b0;
	end

	// negative sums, negative zero included, become zero.
	always_ff @(posedge clk)
	begin
		if (load)
			result <= sum[fp_width-1] ? fp_zero : sum;
	end

	// the last tree stage has to hold its sum while this port is busy.
	sum_held: assert property (@(posedge clk) disable iff (reset)
		sum_valid && full |=> sum_valid)
		else $error("sum dropped while output was busy");

endmodule

// ==== hdl/node_neuron.sv ====
`timescale 1ns/1ps

module node_neuron
(
	input logic clk,
	input logic reset,
	input logic in_req,
	input logic [node_pkg::activation_width-1:0] activations,
	output logic in_ack,
	output logic out_req,
	output fp_pkg::fp_word result,
	input logic out_ack
);
	import fp_pkg::*;
	import node_pkg::*;

	typedef fp_word [node_inputs-1:0] product_vec_t;

	logic advance;
	logic cap_valid;
	logic [activation_width-1:0] cap_data;
	product_vec_t products;
	product_vec_t prod_q;
	logic prod_valid;
	fp_word last_sum;
	logic last_valid;
	logic relu_full;

	// whole pipeline stalls only when the output holds a result and one waits behind it.
	assign advance = !(relu_full && last_valid);

	handshake_in u_handshake_in
	(
		.clk(clk),
		.reset(reset),
		.in_req(in_req),
		.activations(activations),
		.advance(advance),
		.in_ack(in_ack),
		.cap_valid(cap_valid),
		.cap_data(cap_data)
	);

	for (genvar i = 0; i < node_inputs; i++)
	begin : g_mult
		fp_mult u_mult
		(
			.x(cap_data[i*fp_width +: fp_width]),
			.y(node_weights[i]),
			.z(products[i])
		);
	end

	pipe_stage #(.payload_t(product_vec_t)) u_prod_stage
	(
		.clk(clk),
		.reset(reset),
		.advance(advance),
		.in_valid(cap_valid),
		.in_data(products),
		.out_valid(prod_valid),
		.out_data(prod_q)
	);

	for (genvar l = 0; l < tree_levels; l++)
	begin : g_level
		typedef fp_word [level_width[l]-1:0] level_vec_t;

		fp_word [level_inputs[l]-1:0] operands;
		logic operands_valid;
		level_vec_t sums;
		level_vec_t sums_q;
		logic sums_valid;

		if (l == 0)
		begin : g_first
			assign operands = prod_q;
			assign operands_valid = prod_valid;
		end
		else
		begin : g_next
			assign operands = g_level[l-1].sums_q;
			assign operands_valid = g_level[l-1].sums_valid;
		end

		for (genvar p = 0; p < level_width[l]; p++)
		begin : g_pair
			fp_word partner;

			if (2 * p + 1 < level_inputs[l])
			begin : g_pair_b
				assign partner = operands[2*p+1];
			end
			else
			begin : g_pad
				assign partner = fp_zero;   // odd count.
			end

			fp_adder u_add
			(
				.a(operands[2*p]),
				.b(partner),
				.sum(sums[p])
			);
		end

		pipe_stage #(.payload_t(level_vec_t)) u_stage
		(
			.clk(clk),
			.reset(reset),
			.advance(advance),
			.in_valid(operands_valid),
			.in_data(sums),
			.out_valid(sums_valid),
			.out_data(sums_q)
		);
	end

	assign last_sum = g_level[tree_levels-1].sums_q[0];
	assign last_valid = g_level[tree_levels-1].sums_valid;

	relu_out u_relu_out
	(
		.clk(clk),
		.reset(reset),
		.sum_valid(last_valid),
		.sum(last_sum),
		.out_ack(out_ack),
		.out_req(out_req),
		.result(result),
		.full(relu_full)
	);

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock
(
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;   // 10 ns period.
	end

	initial
	begin
		reset = 1'b1;
		repeat (16) @(posedge clk);
		#1 reset = 1'b0;
	end

endmodule

// ==== testbench/tb_node.sv ====
`timescale 1ns/1ps

module tb_node;
	import fp_pkg::*;
	import node_pkg::*;

	localparam fp_word one_val = 32'h3F80_0000;
	localparam fp_word minus_one_val = 32'hBF80_0000;
	localparam fp_word two_val = 32'h4000_0000;
	localparam int pipe_latency = 8;
	localparam int pipe_capacity = 9;   // eight stages and the output register.
	localparam int wait_limit = 400;

	logic clk;
	logic reset;
	logic in_req;
	logic [activation_width-1:0] activations;
	logic in_ack;
	logic out_req;
	fp_word result;
	logic out_ack;

	fp_word exp_q [$];
	int ack_cycle_q [$];
	fp_word exp_head;
	int exp_cycle_head;
	int exp_count;
	int cycle;
	int errors;
	int sent;
	int received;
	int in_flight;
	logic req_seen;
	logic check_latency;
	string test_name;
	int unsigned seed;

	tb_clock u_clock
	(
		.clk(clk),
		.reset(reset)
	);

	node_neuron u_dut
	(
		.clk(clk),
		.reset(reset),
		.in_req(in_req),
		.activations(activations),
		.in_ack(in_ack),
		.out_req(out_req),
		.result(result),
		.out_ack(out_ack)
	);

	always @(posedge clk)
	begin
		if (reset)
			cycle <= 0;
		else
			cycle <= cycle + 1;
	end

	assign in_flight = sent - received;

	// each result belongs to the oldest vector still outstanding.
	result_value: assert property (@(posedge clk) disable iff (reset)
		$rose(out_req) |-> exp_count > 0 && result == exp_head)
		else
		begin
			errors++;
			if (exp_count == 0)
				$display("result %h appeared with no vector outstanding in %s", result,
					test_name);
			else
				$display("Fail %s: expected %h, actual %h", test_name, exp_head, result);
		end

	result_latency: assert property (@(posedge clk) disable iff (reset)
		$rose(out_req) && check_latency |-> cycle == exp_cycle_head + pipe_latency)
		else
		begin
			errors++;
			$display("Fail %s latency: expected cycle %0d, actual cycle %0d", test_name,
				exp_cycle_head + pipe_latency, cycle);
		end

	quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
		!req_seen |-> !in_ack && !out_req)
		else
		begin
			errors++;
			$display("in_ack or out_req went high before any request was made");
		end

	no_ack_in_stall: assert property (@(posedge clk) disable iff (reset)
		!u_dut.advance |=> !$rose(in_ack))
		else
		begin
			errors++;
			$display("in_ack rose while the pipeline was stalled in %s", test_name);
		end

	bounded_in_flight: assert property (@(posedge clk) disable iff (reset)
		in_flight <= pipe_capacity)
		else
		begin
			errors++;
			$display("%0d vectors accepted but not delivered in %s", in_flight, test_name);
		end

	function automatic logic [activation_width-1:0] single_vector(input int idx,
		input fp_word value);
		logic [activation_width-1:0] vec;
		vec = '0;
		vec[idx*fp_width +: fp_width] = value;
		return vec;
	endfunction

	// a lone 1.0, -1.0 or 2.0 gives the weight, negated or with its exponent raised.
	function automatic fp_word scaled_weight(input fp_word weight, input fp_word act);
		fp_word scaled;
		scaled = weight;
		if (act[fp_width-2 -: exp_width] == exp_width'(exp_bias + 1))
			scaled[fp_width-2 -: exp_width] = weight[fp_width-2 -: exp_width] + exp_width'(1);
		if (act[fp_width-1])
			scaled[fp_width-1] = !weight[fp_width-1];
		return scaled;
	endfunction

	function automatic fp_word rectify(input fp_word value);
		return value[fp_width-1] ? fp_zero : value;
	endfunction

	task automatic refresh_head();
		exp_count = exp_q.size();
		if (exp_count > 0)
		begin
			exp_head = exp_q[0];
			exp_cycle_head = ack_cycle_q[0];
		end
	endtask

	task automatic pick_single(input int choices, output logic [activation_width-1:0] vec,
		output fp_word expected);
		int idx;
		fp_word act;
		idx = $urandom % node_inputs;
		case ($urandom % choices)
			0: act = minus_one_val;
			1: act = two_val;
			default: act = one_val;
		endcase
		vec = single_vector(idx, act);
		expected = rectify(scaled_weight(node_weights[idx], act));
	endtask

	task automatic send_vector(input logic [activation_width-1:0] vec, input fp_word expected);
		int waited;
		waited = 0;
		while (in_ack && waited < wait_limit)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		activations = vec;
		in_req = 1'b1;
		req_seen = 1'b1;
		waited = 0;
		while (!in_ack && waited < wait_limit)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (!in_ack)
		begin
			errors++;
			$display("timeout waiting for in_ack in %s", test_name);
		end
		else
		begin
			exp_q.push_back(expected);
			ack_cycle_q.push_back(cycle);   // cycle of the edge that raised in_ack.
			refresh_head();
			sent++;
		end
		in_req = 1'b0;
	endtask

	task automatic take_result(input int hold_cycles);
		int waited;
		waited = 0;
		while (!out_req && waited < wait_limit)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (!out_req)
		begin
			errors++;
			$display("timeout waiting for out_req in %s", test_name);
			return;
		end
		for (int i = 0; i < hold_cycles; i++)
		begin
			@(posedge clk);
			#1;
		end
		out_ack = 1'b1;
		waited = 0;
		while (out_req && waited < wait_limit)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (out_req)
		begin
			errors++;
			$display("timeout waiting for out_req to fall in %s", test_name);
		end
		out_ack = 1'b0;
		if (exp_q.size() > 0)
		begin
			void'(exp_q.pop_front());
			void'(ack_cycle_q.pop_front());
		end
		refresh_head();
		received++;
	endtask

	task automatic send_stream(input int count);
		logic [activation_width-1:0] vec;
		fp_word expected;
		for (int n = 0; n < count; n++)
		begin
			pick_single(3, vec, expected);
			send_vector(vec, expected);
		end
	endtask

	task automatic take_stream(input int count, input int max_hold);
		for (int n = 0; n < count; n++)
			take_result(max_hold > 0 ? $urandom % (max_hold + 1) : 0);
	endtask

	task automatic close_test();
		drained: assert (exp_q.size() == 0 && sent == received)
			else
			begin
				errors++;
				$display("%s ended with %0d results outstanding", test_name, exp_q.size());
			end
	endtask

	initial
	begin
		int waited;
		logic [activation_width-1:0] vec;
		fp_word expected;

		in_req = 1'b0;
		activations = '0;
		out_ack = 1'b0;
		req_seen = 1'b0;
		check_latency = 1'b1;
		errors = 0;
		sent = 0;
		received = 0;
		exp_count = 0;
		exp_head = fp_zero;
		exp_cycle_head = 0;
		test_name = "reset";
		seed = 32'h0fe5_6a07;
		void'($urandom(seed));

		waited = 0;
		while (reset && waited < wait_limit)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (reset)
		begin
			errors++;
			$display("timeout waiting for reset to end");
		end

		// outputs must stay quiet while no request arrives.
		test_name = "idle after reset";
		for (int i = 0; i < 12; i++)
		begin
			@(posedge clk);
			#1;
		end

		test_name = "all zero";
		fork
			send_vector('0, fp_zero);
			take_result(0);
		join
		close_test();

		test_name = "unit activation";
		for (int i = 0; i < node_inputs; i++)
		begin
			fork
				send_vector(single_vector(i, one_val), rectify(node_weights[i]));
				take_result(0);
			join
		end
		close_test();

		test_name = "random single";
		for (int n = 0; n < 20; n++)
		begin
			pick_single(2, vec, expected);
			fork
				send_vector(vec, expected);
				take_result(0);
			join
		end
		close_test();

		test_name = "back to back";
		fork
			send_stream(16);
			take_stream(16, 0);
		join
		close_test();

		test_name = "back pressure";
		check_latency = 1'b0;
		fork
			send_stream(30);
			take_stream(30, 14);
		join
		close_test();

		$display("errors: %0d, vectors sent: %0d, results received: %0d", errors, sent, received);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== project.f ====
hdl/fp_pkg.sv
hdl/node_pkg.sv
hdl/fp_mult.sv
hdl/fp_adder.sv
hdl/pipe_stage.sv
hdl/handshake_in.sv
hdl/relu_out.sv
hdl/node_neuron.sv
testbench/tb_clock.sv
testbench/tb_node.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the neuron testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal -f project.f --top-module tb_node -o sim_node; then
	echo "verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/sim_node)
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_output" | grep -qx "ALL TESTS PASSED"; then
	exit 0
fi

echo "simulation did not report a pass"
exit 1
